// ==== sim.f ====
pipe_pkg.sv
data_mem.sv
input_unit.sv
hazard_unit.sv
mem_wb_reg.sv
general_reg.sv
mem_wb_top.sv
mem_wb_chk.sv
tb_mem_wb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the mem/wb testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_mem_wb -o sim_tb
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^All checks passed$" sim.log; then
    exit 0
fi
exit 1

// ==== tb_mem_wb.sv ====
`timescale 1ns/1ps

module tb_mem_wb;
    import pipe_pkg::*;

    localparam int STALL_LIMIT = 20;                         // cycles before a stall wait gives up

    typedef enum logic [1:0] {OP_ALU, OP_STORE, OP_LOAD} op_e;
    typedef enum logic [2:0] {ACT_NONE, ACT_KEYPAD, ACT_SWITCH, ACT_FLUSH, ACT_NOOP} act_e;

    typedef struct packed {
        op_e                  op;
        logic [4:0]           dest;
        logic [ISA_WIDTH-1:0] addr_val;                      // alu value or byte address
        logic [ISA_WIDTH-1:0] sdata;                         // store word, keypad word or switches
        act_e                 act;
        logic [ISA_WIDTH-1:0] exp_val;                       // dest register after the item
    } stim_t;

    logic                            clk = 1'b0;
    logic                            rst_n;
    mem_stage_t                      mem_in;
    logic                            flush;
    logic                            keypad_valid;
    logic [ISA_WIDTH-1:0]            keypad_data;
    logic                            switch_confirm;
    logic [SWITCH_CNT-1:0]           switch_map;
    logic [REG_FILE_ADDR_WIDTH-1:0]  rd_idx;
    logic [ISA_WIDTH-1:0]            rd_data;
    logic                            stall;
    fwd_t                            fwd;

    stim_t                stim_q [$];
    logic [ISA_WIDTH-1:0] shadow_reg [32];                   // reference register file
    logic [ISA_WIDTH-1:0] shadow_mem [256];                  // reference data ram
    integer               seed;
    int                   err_cnt;
    int                   check_cnt;

    always #20 clk = ~clk;

    mem_wb_top i_mem_wb_top (
        .clk, .rst_n, .mem_in, .flush, .keypad_valid, .keypad_data, .switch_confirm,
        .switch_map, .rd_idx, .rd_data, .stall, .fwd
    );

    task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // reference model predicts the dest register as the item leaves the pipe
    task automatic add_entry(input op_e op, input logic [4:0] dest, input logic [31:0] av,
                             input logic [31:0] sd, input act_e act);
        stim_t       s;
        logic        live;
        logic [31:0] val;
        live = (act != ACT_FLUSH) && (act != ACT_NOOP);      // killed items change nothing
        val  = av;
        if (op == OP_LOAD) begin
            if (act == ACT_KEYPAD) val = sd;
            else if (act == ACT_SWITCH) val = {16'd0, sd[15:0]};
            else val = shadow_mem[av[9:2]];                  // word index from bit 2
        end
        if (op == OP_STORE) begin
            if (live && av != IO_INPUT_ADDR) shadow_mem[av[9:2]] = sd;
        end else if (live && dest != 5'd0) begin
            shadow_reg[dest] = val;
        end
        s = '{op: op, dest: dest, addr_val: av, sdata: sd, act: act, exp_val: shadow_reg[dest]};
        stim_q.push_back(s);
    endtask

    task automatic build_table();
        logic [31:0] word_a;
        logic [31:0] word_b;
        foreach (shadow_reg[i]) shadow_reg[i] = '0;
        foreach (shadow_mem[i]) shadow_mem[i] = '0;
        word_a = $random(seed);
        word_b = $random(seed);
        add_entry(OP_ALU,   5'd1,  $random(seed), '0, ACT_NONE);
        add_entry(OP_ALU,   5'd2,  $random(seed), '0, ACT_NONE);
        add_entry(OP_ALU,   5'd0,  $random(seed), '0, ACT_NONE);     // r0 keeps zero
        add_entry(OP_ALU,   5'd31, $random(seed), '0, ACT_NONE);
        add_entry(OP_STORE, 5'd1,  32'h40, word_a, ACT_NONE);        // r1 must not change
        add_entry(OP_LOAD,  5'd3,  32'h40, '0, ACT_NONE);
        add_entry(OP_LOAD,  5'd9,  32'h43, '0, ACT_NONE);            // byte offset ignored
        add_entry(OP_STORE, 5'd2,  32'h70, word_b, ACT_NONE);        // aliases the port word
        add_entry(OP_STORE, 5'd31, IO_INPUT_ADDR, $random(seed), ACT_NONE);
        add_entry(OP_LOAD,  5'd4,  32'h70, '0, ACT_NONE);
        add_entry(OP_LOAD,  5'd5,  IO_INPUT_ADDR, $random(seed), ACT_KEYPAD);
        add_entry(OP_LOAD,  5'd6,  IO_INPUT_ADDR, $random(seed), ACT_SWITCH);
        add_entry(OP_ALU,   5'd1,  $random(seed), '0, ACT_FLUSH);
        add_entry(OP_ALU,   5'd2,  $random(seed), '0, ACT_NOOP);
        add_entry(OP_LOAD,  5'd7,  IO_INPUT_ADDR, $random(seed), ACT_KEYPAD);
        add_entry(OP_ALU,   5'd7,  $random(seed), '0, ACT_NONE);
        add_entry(OP_LOAD,  5'd8,  32'h3FC, '0, ACT_NONE);           // never written
    endtask

    task automatic run_item(input int n, input stim_t s);
        int   waited;
        logic wr_exp;
        @(posedge clk);
        #2;
        if (s.act == ACT_SWITCH) begin
            switch_map     = s.sdata[15:0];
            switch_confirm = 1'b1;
            @(posedge clk);
            #2;
            switch_confirm = 1'b0;
        end
        mem_in                  = '0;
        mem_in.dest_reg_idx     = s.dest;
        mem_in.alu_result       = s.addr_val;
        mem_in.store_data       = s.sdata;
        mem_in.reg_write_enable = (s.op != OP_STORE);
        mem_in.mem_read_enable  = (s.op == OP_LOAD);
        mem_in.mem_write_enable = (s.op == OP_STORE);
        mem_in.no_op            = (s.act == ACT_NOOP);
        flush                   = (s.act == ACT_FLUSH);
        #1;
        check_val($sformatf("stall on item %0d", n), 32'(stall), 32'(s.act == ACT_KEYPAD));
        waited = 0;
        while (stall && waited < STALL_LIMIT) begin
            @(posedge clk);
            #2;
            waited++;
            if (waited == 1) mem_in.no_op = 1'b1;            // upstream cancels the held copy
            keypad_valid = (waited == 3);                    // user types after a while
            keypad_data  = s.sdata;
            #1;
        end
        if (stall) begin
            err_cnt++;
            $display("timeout: stall on item %0d did not fall within %0d cycles", n, STALL_LIMIT);
        end
        @(posedge clk);                                      // item enters wb
        #2;
        mem_in       = '0;                                   // bubble behind it
        flush        = 1'b0;
        keypad_valid = 1'b0;
        // only a live non-store item to a real register is offered for forwarding
        wr_exp = (s.op != OP_STORE) && (s.act != ACT_FLUSH) && (s.act != ACT_NOOP)
                 && (s.dest != 5'd0);
        check_val($sformatf("fwd.valid on item %0d", n), 32'(fwd.valid), 32'(wr_exp));
        if (wr_exp) begin
            check_val($sformatf("fwd.dest_reg_idx on item %0d", n), 32'(fwd.dest_reg_idx),
                      32'(s.dest));
            check_val($sformatf("fwd.value on item %0d", n), fwd.value, s.exp_val);
        end
        @(posedge clk);                                      // register file write
        #2;
        rd_idx = s.dest;
        #1;
        check_val($sformatf("r%0d after item %0d", s.dest, n), rd_data, s.exp_val);
    endtask

    initial begin
        seed           = 32'hc7e28627;
        err_cnt        = 0;
        check_cnt      = 0;
        rst_n          = 1'b0;
        mem_in         = '0;
        flush          = 1'b0;
        keypad_valid   = 1'b0;
        keypad_data    = '0;
        switch_confirm = 1'b0;
        switch_map     = '0;
        rd_idx         = '0;
        build_table();
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_val("stall after reset", 32'(stall), 32'd0);
        check_val("fwd.valid after reset", 32'(fwd.valid), 32'd0);
        for (int i = 0; i < 32; i++) begin
            rd_idx = 5'(i);
            #1;
            check_val($sformatf("r%0d after reset", i), rd_data, 32'd0);
        end
        foreach (stim_q[i]) run_item(i, stim_q[i]);
        for (int i = 0; i < 32; i++) begin                   // whole file against the model
            rd_idx = 5'(i);
            #1;
            check_val($sformatf("r%0d at end", i), rd_data, shadow_reg[i]);
        end
        $display("checks %0d, errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== mem_wb_chk.sv ====
`timescale 1ns/1ps

module mem_wb_chk (
    input logic                clk,
    input logic                rst_n,
    input pipe_pkg::hazd_ctl_e hazard_control,  // hazard_unit output
    input logic                stall,
    input pipe_pkg::wb_stage_t wb               // mem_wb_reg state
);
    import pipe_pkg::*;

    // wb frozen while waiting for user input
    a_retry_hold: assert property (@(posedge clk) disable iff (!rst_n)
        hazard_control == HAZD_CTL_RETRY |=> $stable(wb))
        else $error("wb changed during a retry cycle");

    a_noop_mark: assert property (@(posedge clk) disable iff (!rst_n)
        hazard_control == HAZD_CTL_NO_OP |=> wb.no_op)
        else $error("no-op code did not set wb.no_op");

    // first clock out of reset
    a_reset_stall: assert property (@(posedge clk) $rose(rst_n) |-> !stall)
        else $error("stall high right after reset");

endmodule

bind mem_wb_top mem_wb_chk i_mem_wb_chk (
    .clk, .rst_n, .hazard_control, .stall, .wb
);

// ==== mem_wb_top.sv ====
`timescale 1ns/1ps

module mem_wb_top (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  pipe_pkg::mem_stage_t                     mem_in,          // ready memory-stage bundle
    input  logic                                     flush,           // kill current mem item
    input  logic                                     keypad_valid,
    input  logic [pipe_pkg::ISA_WIDTH-1:0]           keypad_data,
    input  logic                                     switch_confirm,
    input  logic [pipe_pkg::SWITCH_CNT-1:0]          switch_map,
    input  logic [pipe_pkg::REG_FILE_ADDR_WIDTH-1:0] rd_idx,
    output logic [pipe_pkg::ISA_WIDTH-1:0]           rd_data,
    output logic                                     stall,           // hold mem_in upstream
    output pipe_pkg::fwd_t                           fwd
);
    import pipe_pkg::*;

    hazd_ctl_e            hazard_control;
    wb_stage_t            wb;
    logic [ISA_WIDTH-1:0] mem_read_data;
    logic [ISA_WIDTH-1:0] keypad_word;
    logic                 input_select;
    logic                 input_complete;
    logic                 switch_enable;
    logic                 ignore_no_op;
    logic                 consume;

    data_mem i_data_mem (
        .clk, .rst_n, .mem_in, .hazard_control, .mem_read_data, .input_select
    );

    input_unit i_input_unit (
        .clk, .rst_n, .keypad_valid, .keypad_data, .switch_confirm, .consume,
        .input_complete, .switch_enable, .keypad_word
    );

    hazard_unit i_hazard_unit (
        .clk, .rst_n, .flush, .input_select, .input_complete,
        .hazard_control, .ignore_no_op, .consume, .stall
    );

    mem_wb_reg i_mem_wb_reg (
        .clk, .rst_n, .hazard_control, .ignore_no_op, .mem_in, .mem_read_data,
        .input_select, .input_complete, .switch_enable, .keypad_word, .switch_map, .wb
    );

    general_reg i_general_reg (
        .clk, .rst_n, .wb, .rd_idx, .rd_data, .fwd
    );

endmodule

// ==== general_reg.sv ====
`timescale 1ns/1ps

module general_reg (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  pipe_pkg::wb_stage_t                      wb,       // from mem_wb_reg
    input  logic [pipe_pkg::REG_FILE_ADDR_WIDTH-1:0] rd_idx,   // read port index
    output logic [pipe_pkg::ISA_WIDTH-1:0]           rd_data,  // combinational read
    output pipe_pkg::fwd_t                           fwd       // write-back bundle for forwarding
);
    import pipe_pkg::*;

    localparam int REG_CNT = 1 << REG_FILE_ADDR_WIDTH;

    logic [ISA_WIDTH-1:0] regs [REG_CNT];
    logic [ISA_WIDTH-1:0] wb_value;
    logic                 wr_fire;

    // load data or alu result
    assign wb_value = wb.mem_read_enable ? wb.mem_read_data : wb.alu_result;

    // r0 is never written
    assign wr_fire = wb.reg_write_enable & ~wb.no_op & (wb.dest_reg_idx != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_fire) begin
            regs[wb.dest_reg_idx] <= wb_value;
        end
    end

    assign rd_data = regs[rd_idx];                           // r0 stays zero from reset

    assign fwd.valid        = wr_fire;
    assign fwd.dest_reg_idx = wb.dest_reg_idx;
    assign fwd.value        = wb_value;                      // same value the array gets

endmodule

// ==== mem_wb_reg.sv ====
`timescale 1ns/1ps

module mem_wb_reg (
    input  logic                            clk,
    input  logic                            rst_n,
    input  pipe_pkg::hazd_ctl_e             hazard_control,  // from hazard_unit
    input  logic                            ignore_no_op,    // from hazard_unit
    input  pipe_pkg::mem_stage_t            mem_in,          // item in the memory stage
    input  logic [pipe_pkg::ISA_WIDTH-1:0]  mem_read_data,   // from data_mem
    input  logic                            input_select,    // load from the input port
    input  logic                            input_complete,  // user input is ready
    input  logic                            switch_enable,   // input came from switches
    input  logic [pipe_pkg::ISA_WIDTH-1:0]  keypad_word,     // from input_unit
    input  logic [pipe_pkg::SWITCH_CNT-1:0] switch_map,      // raw toggle switches
    output pipe_pkg::wb_stage_t             wb               // for general_reg
);
    import pipe_pkg::*;

    logic [ISA_WIDTH-1:0] user_word;
    logic [ISA_WIDTH-1:0] read_word;

    // switches are zero-extended to a full word
    assign user_word = switch_enable ? {{(ISA_WIDTH - SWITCH_CNT){1'b0}}, switch_map}
                                     : keypad_word;

    assign read_word = (input_select && input_complete) ? user_word : mem_read_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb <= '0;                                        // all fields clear
        end else begin
            unique case (hazard_control)
                HAZD_CTL_NO_OP: begin
                    wb.no_op <= 1'b1;                        // rest of wb is don't care
                end
                HAZD_CTL_RETRY: begin
                    wb <= wb;                                // hold while waiting for input
                end
                default: begin
                    wb.no_op            <= mem_in.no_op & ~ignore_no_op;
                    wb.reg_write_enable <= mem_in.reg_write_enable;
                    wb.mem_read_enable  <= mem_in.mem_read_enable;
                    wb.alu_result       <= mem_in.alu_result;
                    wb.mem_read_data    <= read_word;
                    wb.dest_reg_idx     <= mem_in.dest_reg_idx;
                end
            endcase
        end
    end

endmodule

// ==== hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush,           // one-cycle kill of the mem item
    input  logic                input_select,    // from data_mem
    input  logic                input_complete,  // from input_unit
    output pipe_pkg::hazd_ctl_e hazard_control,  // next state of the wb stage
    output logic                ignore_no_op,    // release cycle after a retry
    output logic                consume,         // input word is taken this cycle
    output logic                stall            // upstream must hold mem_in
);
    import pipe_pkg::*;

    hazd_ctl_e hazd_next;
    logic      retry_q;                                      // last cycle was RETRY

    // flush first, then a pending input wait, else advance
    always_comb begin
        if (flush) begin
            hazd_next = HAZD_CTL_NO_OP;
        end else if (input_select && !input_complete) begin
            hazd_next = HAZD_CTL_RETRY;                       // user has not typed yet
        end else begin
            hazd_next = HAZD_CTL_NORMAL;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retry_q <= 1'b0;
        end else begin
            retry_q <= (hazd_next == HAZD_CTL_RETRY);
        end
    end

    assign hazard_control = hazd_next;
    assign stall          = (hazd_next == HAZD_CTL_RETRY);

    // upstream marks the held item no_op one cycle after stall,
    // so the first NORMAL after a RETRY must look past that flag
    assign ignore_no_op = retry_q & (hazd_next == HAZD_CTL_NORMAL);

    assign consume = input_select & (hazd_next == HAZD_CTL_NORMAL);  // implies complete

endmodule

// ==== input_unit.sv ====
`timescale 1ns/1ps

module input_unit (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           keypad_valid,    // one-cycle strobe from the keypad
    input  logic [pipe_pkg::ISA_WIDTH-1:0] keypad_data,     // word typed by the user
    input  logic                           switch_confirm,  // one-cycle strobe when switches are set
    input  logic                           consume,         // wb stage took the input
    output logic                           input_complete,  // an input word is waiting
    output logic                           switch_enable,   // 1 for switches, 0 for keypad
    output logic [pipe_pkg::ISA_WIDTH-1:0] keypad_word      // latched keypad word
);
    import pipe_pkg::*;

    logic [ISA_WIDTH-1:0] keypad_q;                          // keypad payload

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            input_complete <= 1'b0;
            switch_enable  <= 1'b0;
        end else begin
            if (consume) begin
                input_complete <= 1'b0;                      // word was used, wait for next
            end
            // a fresh strobe wins over consume in the same cycle
            if (keypad_valid) begin
                input_complete <= 1'b1;
                switch_enable  <= 1'b0;
            end else if (switch_confirm) begin
                input_complete <= 1'b1;
                switch_enable  <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (keypad_valid) begin
            keypad_q <= keypad_data;                         // hold until the next keypad strobe
        end
    end

    assign keypad_word = keypad_q;

endmodule

// ==== data_mem.sv ====
`timescale 1ns/1ps

module data_mem (
    input  logic                           clk,
    input  logic                           rst_n,
    input  pipe_pkg::mem_stage_t           mem_in,          // item in the memory stage
    input  pipe_pkg::hazd_ctl_e            hazard_control,  // from hazard_unit
    output logic [pipe_pkg::ISA_WIDTH-1:0] mem_read_data,   // async read of the addressed word
    output logic                           input_select     // load targets the input port
);
    import pipe_pkg::*;

    logic [ISA_WIDTH-1:0]       ram [DMEM_DEPTH];           // word array
    logic [DMEM_ADDR_WIDTH-1:0] word_idx;
    logic                       io_hit;
    logic                       write_fire;

    // low two bits select a byte and are ignored
    assign word_idx = mem_in.alu_result[DMEM_IDX_LSB +: DMEM_ADDR_WIDTH];

    assign io_hit       = (mem_in.alu_result == IO_INPUT_ADDR);  // full address compare
    assign input_select = mem_in.mem_read_enable & io_hit;       // load from user input

    assign mem_read_data = ram[word_idx];                         // no read latency

    // store lands only on a live item in a NORMAL cycle and never on the port address
    assign write_fire = mem_in.mem_write_enable
                      & ~mem_in.no_op
                      & ~io_hit
                      & (hazard_control == HAZD_CTL_NORMAL);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                ram[i] <= '0;                                     // clear whole ram
            end
        end else if (write_fire) begin
            ram[word_idx] <= mem_in.store_data;
        end
    end

endmodule

// ==== pipe_pkg.sv ====
package pipe_pkg;

    localparam int ISA_WIDTH           = 32;                      // data word width
    localparam int REG_FILE_ADDR_WIDTH = 5;                       // 32 registers
    localparam int SWITCH_CNT          = 16;                      // toggle switches on the board
    localparam int DMEM_DEPTH          = 256;                     // data ram words
    localparam int DMEM_ADDR_WIDTH     = $clog2(DMEM_DEPTH);      // word index bits
    localparam int DMEM_IDX_LSB        = 2;                       // byte address to word index

    localparam logic [ISA_WIDTH-1:0] IO_INPUT_ADDR = 32'hFFFF_FC70;  // load here reads user input

    // next state of the wb stage chosen each cycle
    typedef enum logic [1:0] {
        HAZD_CTL_NORMAL = 2'd0,                                   // advance
        HAZD_CTL_RETRY  = 2'd1,                                   // hold while waiting for input
        HAZD_CTL_NO_OP  = 2'd2                                    // kill the current item
    } hazd_ctl_e;

    typedef struct packed {
        logic                           no_op;                    // item already cancelled upstream
        logic                           reg_write_enable;
        logic                           mem_read_enable;          // load
        logic                           mem_write_enable;         // store
        logic [ISA_WIDTH-1:0]           alu_result;               // result or byte address
        logic [ISA_WIDTH-1:0]           store_data;
        logic [REG_FILE_ADDR_WIDTH-1:0] dest_reg_idx;
    } mem_stage_t;

    typedef struct packed {
        logic                           no_op;                    // suppresses the register write
        logic                           reg_write_enable;
        logic                           mem_read_enable;          // picks mem_read_data on write-back
        logic [ISA_WIDTH-1:0]           alu_result;
        logic [ISA_WIDTH-1:0]           mem_read_data;            // ram word or user input
        logic [REG_FILE_ADDR_WIDTH-1:0] dest_reg_idx;
    } wb_stage_t;

    typedef struct packed {
        logic                           valid;                    // a real write is in wb
        logic [REG_FILE_ADDR_WIDTH-1:0] dest_reg_idx;
        logic [ISA_WIDTH-1:0]           value;                    // write-back value
    } fwd_t;

endpackage
